//--- hw/dsp_pkg.sv
// shared widths, types and register map for the readout DSP
// imported by every RTL block and by the testbench
package dsp_pkg;

	// adc and baseband samples
	localparam int SAMPLE_WIDTH = 16;
	localparam int NADC = 2;
	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	// accumulated window sum
	localparam int ACC_WIDTH = 32;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// shot count, also used for nshot
	typedef logic [31:0] shotcnt_t;

	// lane source select, values past NADC-1 give zero
	typedef logic [1:0] lanesel_t;

	// apb bus
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// registers to sequencer
	typedef struct packed {
		logic start;
		shotcnt_t nshot;
	} seq_ctrl_t;

	// sequencer back to registers
	typedef struct packed {
		logic lastshotdone;
		shotcnt_t shots_done;
	} seq_status_t;

	// one readout lane, sample with its gate
	typedef struct packed {
		sample_t sample;
		logic gate;
	} bb_lane_t;

	// neighbouring states differ in one bit
	typedef enum logic [3:0] {
		IDLE = 4'b0000,
		START = 4'b0001,
		PROCRUN = 4'b0011,
		ELEMBUSY = 4'b0010,
		MORESHOT = 4'b0110,
		SHOTADD = 4'b0111,
		DONE = 4'b0101
	} seq_state_e;

	// register offsets
	localparam apb_addr_t REG_CTRL = 8'h00;
	localparam apb_addr_t REG_NSHOT = 8'h04;
	localparam apb_addr_t REG_LANESEL = 8'h08;
	localparam apb_addr_t REG_STATUS = 8'h0C;
	localparam apb_addr_t REG_SHOTS = 8'h10;

endpackage

//--- hw/dsp_regs.sv
// apb register block: run control, shot count, lane selects and status
// host writes nshot, then sets ctrl bit 0 to start a run
`timescale 1ns/1ps

module dsp_regs (
	input logic dspif,
	input logic reset,
	input dsp_pkg::apb_req_t apb_req,
	output dsp_pkg::apb_rsp_t apb_rsp,
	output dsp_pkg::seq_ctrl_t seq_ctrl,
	input dsp_pkg::seq_status_t seq_status,
	output logic resetacc,
	output dsp_pkg::lanesel_t lane1_sel,
	output dsp_pkg::lanesel_t lane2_sel
);
	import dsp_pkg::*;

	logic access;
	logic addr_ok;
	logic addr_ro;
	logic wr_en;
	apb_data_t rdata;
	shotcnt_t nshot_q;
	logic start_q;
	logic resetacc_q;
	lanesel_t lane1_q;
	lanesel_t lane2_q;

	// access phase, pready is always high so this lasts one cycle
	assign access = apb_req.psel & apb_req.penable;

	// address decode and read mux
	always_comb begin
		addr_ok = 1'b1;
		addr_ro = 1'b0;
		rdata = '0;
		case (apb_req.paddr)
			// start bit reads back as 0
			REG_CTRL: rdata = {30'd0, resetacc_q, 1'b0};
			REG_NSHOT: rdata = nshot_q;
			REG_LANESEL: rdata = {28'd0, lane2_q, lane1_q};
			REG_STATUS: begin
				rdata = {31'd0, seq_status.lastshotdone};
				addr_ro = 1'b1;
			end
			REG_SHOTS: begin
				rdata = seq_status.shots_done;
				addr_ro = 1'b1;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	// bad accesses change nothing
	assign wr_en = access & apb_req.pwrite & addr_ok & ~addr_ro;

	always_ff @(posedge dspif) begin
		if (reset) begin
			start_q <= 1'b0;
			resetacc_q <= 1'b0;
			nshot_q <= '0;
			// adc 0 on lane 1, adc 1 on lane 2
			lane1_q <= 2'd0;
			lane2_q <= 2'd1;
		end else begin
			// strobe clears itself after one cycle
			start_q <= wr_en && apb_req.paddr == REG_CTRL && apb_req.pwdata[0];
			if (wr_en) begin
				case (apb_req.paddr)
					REG_CTRL: resetacc_q <= apb_req.pwdata[1];
					REG_NSHOT: nshot_q <= apb_req.pwdata;
					REG_LANESEL: begin
						lane1_q <= apb_req.pwdata[1:0];
						lane2_q <= apb_req.pwdata[3:2];
					end
					default: ;
				endcase
			end
		end
	end

	assign apb_rsp.prdata = rdata;
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & addr_ro));

	assign seq_ctrl.start = start_q;
	assign seq_ctrl.nshot = nshot_q;
	assign resetacc = resetacc_q;
	assign lane1_sel = lane1_q;
	assign lane2_sel = lane2_q;

	// host must hold psel through the access phase
	a_penable_psel: assert property (@(posedge dspif) disable iff (reset)
		apb_req.penable |-> apb_req.psel);

endmodule

//--- hw/shot_sequencer.sv
// runs the processor group for nshot shots, nshot of 0 runs forever
// processors are held in reset between shots, lastshotdone marks the end of a run
`timescale 1ns/1ps

module shot_sequencer #(
	parameter int NPROC = 4
) (
	input logic dspif,
	input logic reset,
	input dsp_pkg::seq_ctrl_t seq_ctrl,
	input logic [NPROC-1:0] procdone,
	input logic [NPROC-1:0] nobusy,
	output logic procreset,
	output dsp_pkg::seq_status_t seq_status
);
	import dsp_pkg::*;

	seq_state_e state;
	seq_state_e nextstate;
	logic procdone_r;
	logic nobusy_r;
	shotcnt_t nshot_q;
	shotcnt_t shot_cnt;
	logic more_shots;
	logic procreset_q;
	logic lastshotdone_q;

	// keep going until the count matches, or forever for nshot 0
	assign more_shots = (shot_cnt != nshot_q) || (nshot_q == '0);

	always_comb begin
		nextstate = state;
		case (state)
			IDLE: begin
				if (seq_ctrl.start) begin
					nextstate = START;
				end
			end
			START: nextstate = PROCRUN;
			// wait for every processor to finish its program
			PROCRUN: begin
				if (procdone_r) begin
					nextstate = ELEMBUSY;
				end
			end
			// then for every element to go idle
			ELEMBUSY: begin
				if (nobusy_r) begin
					nextstate = MORESHOT;
				end
			end
			MORESHOT: nextstate = more_shots ? SHOTADD : DONE;
			SHOTADD: nextstate = START;
			DONE: nextstate = IDLE;
			default: nextstate = IDLE;
		endcase
	end

	// processor handshakes, one register stage, all bits anded
	always_ff @(posedge dspif) begin
		procdone_r <= &procdone;
		nobusy_r <= &nobusy;
		// shot target is picked up while idle
		if (state == IDLE) begin
			nshot_q <= seq_ctrl.nshot;
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= IDLE;
			procreset_q <= 1'b1;
			shot_cnt <= '0;
			lastshotdone_q <= 1'b0;
		end else begin
			state <= nextstate;
			// processors run only in START and PROCRUN
			procreset_q <= !(nextstate == START || nextstate == PROCRUN);
			if (state == IDLE && seq_ctrl.start) begin
				shot_cnt <= '0;
				lastshotdone_q <= 1'b0;
			end else if (state == ELEMBUSY && nobusy_r) begin
				// shot finished, count it before the more-shots check
				shot_cnt <= shot_cnt + 1'b1;
			end
			if (nextstate == DONE) begin
				lastshotdone_q <= 1'b1;
			end
		end
	end

	assign procreset = procreset_q;
	assign seq_status.lastshotdone = lastshotdone_q;
	assign seq_status.shots_done = shot_cnt;

	a_state_legal: assert property (@(posedge dspif) disable iff (reset)
		state inside {IDLE, START, PROCRUN, ELEMBUSY, MORESHOT, SHOTADD, DONE});

endmodule

//--- hw/bb_select.sv
// baseband source select for the two readout lanes
// two register stages, gate rides along with the samples
`timescale 1ns/1ps

module bb_select (
	input logic dspif,
	input dsp_pkg::sample_t adc [dsp_pkg::NADC],
	input logic gate,
	input dsp_pkg::lanesel_t lane1_sel,
	input dsp_pkg::lanesel_t lane2_sel,
	output dsp_pkg::bb_lane_t lane1,
	output dsp_pkg::bb_lane_t lane2
);
	import dsp_pkg::*;

	sample_t adc_q [NADC];
	logic gate_q;

	// unmapped select gives a zero sample
	function automatic sample_t pick(input lanesel_t sel, input sample_t src [NADC]);
		sample_t res;
		res = '0;
		for (int i = 0; i < NADC; i++) begin
			if (sel == lanesel_t'(i)) begin
				res = src[i];
			end
		end
		return res;
	endfunction

	// stage 1, adc inputs and gate
	always_ff @(posedge dspif) begin
		adc_q <= adc;
		gate_q <= gate;
	end

	// stage 2, per lane mux
	always_ff @(posedge dspif) begin
		lane1.sample <= pick(lane1_sel, adc_q);
		lane1.gate <= gate_q;
		lane2.sample <= pick(lane2_sel, adc_q);
		lane2.gate <= gate_q;
	end

endmodule

//--- hw/acc_writer.sv
// one readout channel: sums lane samples over the gate window
// writes the sum to the accumulation buffer when the gate falls
`timescale 1ns/1ps

module acc_writer #(
	parameter int ACC_ADDR_WIDTH = 10
) (
	input logic dspif,
	input logic reset,
	input logic resetacc,
	input dsp_pkg::bb_lane_t lane,
	output logic we,
	output logic [ACC_ADDR_WIDTH-1:0] addr,
	output dsp_pkg::acc_t data,
	output logic meas
);
	import dsp_pkg::*;

	acc_t sample_ext;
	acc_t sum;
	logic gate_d;
	logic gate_fall;
	logic we_q;
	logic [ACC_ADDR_WIDTH-1:0] addr_q;

	assign sample_ext = {{(ACC_WIDTH-SAMPLE_WIDTH){lane.sample[SAMPLE_WIDTH-1]}}, lane.sample};
	assign gate_fall = gate_d & ~lane.gate;

	// window sum, first gated sample restarts it
	always_ff @(posedge dspif) begin
		if (lane.gate) begin
			sum <= gate_d ? sum + sample_ext : sample_ext;
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			gate_d <= 1'b0;
			we_q <= 1'b0;
			addr_q <= '0;
		end else begin
			gate_d <= lane.gate;
			we_q <= gate_fall;
			// address moves after each write and sticks at the last entry
			if (resetacc) begin
				addr_q <= '0;
			end else if (we_q && !(&addr_q)) begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	assign we = we_q;
	assign addr = addr_q;
	// sum is stable once the gate is low
	assign data = sum;
	// state estimate from the sign of the in-phase sum
	assign meas = sum[ACC_WIDTH-1];

	a_addr_no_wrap: assert property (@(posedge dspif) disable iff (reset)
		(&addr_q && !resetacc) |=> addr_q != '0);

endmodule

//--- hw/dsp_top.sv
// readout DSP top: apb registers, shot sequencer, lane select, accumulators
// channels below NDLO1 read lane 1, the rest lane 2
`timescale 1ns/1ps

module dsp_top #(
	parameter int NPROC = 4,
	parameter int NDLO = 4,
	parameter int NDLO1 = 2,
	parameter int ACC_ADDR_WIDTH = 10
) (
	input logic dspif,
	input logic reset,
	input dsp_pkg::apb_req_t apb_req,
	output dsp_pkg::apb_rsp_t apb_rsp,
	input dsp_pkg::sample_t adc [dsp_pkg::NADC],
	input logic gate,
	input logic [NPROC-1:0] procdone,
	input logic [NPROC-1:0] nobusy,
	output logic procreset,
	output logic acc_we [NDLO],
	output logic [ACC_ADDR_WIDTH-1:0] acc_addr [NDLO],
	output dsp_pkg::acc_t acc_data [NDLO],
	output logic meas [NDLO]
);
	import dsp_pkg::*;

	seq_ctrl_t seq_ctrl;
	seq_status_t seq_status;
	logic resetacc;
	lanesel_t lane1_sel;
	lanesel_t lane2_sel;
	bb_lane_t lane1;
	bb_lane_t lane2;

	// host access
	dsp_regs u_regs (
		.dspif(dspif),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.seq_ctrl(seq_ctrl),
		.seq_status(seq_status),
		.resetacc(resetacc),
		.lane1_sel(lane1_sel),
		.lane2_sel(lane2_sel)
	);

	shot_sequencer #(.NPROC(NPROC)) u_seq (
		.dspif(dspif),
		.reset(reset),
		.seq_ctrl(seq_ctrl),
		.procdone(procdone),
		.nobusy(nobusy),
		.procreset(procreset),
		.seq_status(seq_status)
	);

	// adc to lanes, 2 cycles
	bb_select u_bb (
		.dspif(dspif),
		.adc(adc),
		.gate(gate),
		.lane1_sel(lane1_sel),
		.lane2_sel(lane2_sel),
		.lane1(lane1),
		.lane2(lane2)
	);

	for (genvar i = 0; i < NDLO; i++) begin : g_acc
		acc_writer #(.ACC_ADDR_WIDTH(ACC_ADDR_WIDTH)) u_acc (
			.dspif(dspif),
			.reset(reset),
			.resetacc(resetacc),
			.lane((i < NDLO1) ? lane1 : lane2),
			.we(acc_we[i]),
			.addr(acc_addr[i]),
			.data(acc_data[i]),
			.meas(meas[i])
		);
	end

endmodule

//--- tests/tb_dsp_top.sv
// testbench for the readout DSP top level
// drives apb, adc samples, gate and a processor model and checks every buffer write
`timescale 1ns/1ps

module tb_dsp_top;
	import dsp_pkg::*;

	localparam int NDLO = 4;
	localparam int NDLO1 = 2;
	localparam int AW = 3;
	localparam int MAXW = 8;

	logic dspif;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	sample_t adc [NADC];
	logic gate;
	logic [3:0] procdone;
	logic [3:0] nobusy;
	logic procreset;
	logic acc_we [NDLO];
	logic [AW-1:0] acc_addr [NDLO];
	acc_t acc_data [NDLO];
	logic meas [NDLO];

	integer seed = 98634;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_err;
	string test_name = "reset";
	int fall_cnt = 0;
	int sel1 = 0;
	int sel2 = 1;
	logic [AW-1:0] addr_model = '0;

	// one entry per gate window since all channels write together
	acc_t exp_lane1 [$];
	acc_t exp_lane2 [$];
	logic [AW-1:0] exp_addr [$];

	dsp_top #(.ACC_ADDR_WIDTH(AW)) dut0 (
		.dspif(dspif),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.adc(adc),
		.gate(gate),
		.procdone(procdone),
		.nobusy(nobusy),
		.procreset(procreset),
		.acc_we(acc_we),
		.acc_addr(acc_addr),
		.acc_data(acc_data),
		.meas(meas)
	);

	initial begin
		dspif = 1'b0;
		forever #4 dspif = ~dspif;
	end

	// one processor start per shot
	always @(negedge procreset) fall_cnt++;

	// expected window sum with each sample sign extended to the accumulator width
	function automatic acc_t window_sum(input sample_t smp [MAXW], input int n);
		acc_t total;
		total = '0;
		for (int k = 0; k < n; k++) begin
			total = total + acc_t'(smp[k]);
		end
		return total;
	endfunction

	// setup cycle then access cycle with read data taken mid access phase
	task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_data_t wd,
			output apb_data_t rd, output logic err);
		@(posedge dspif);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: wd};
		@(posedge dspif);
		apb_req.penable <= 1'b1;
		@(negedge dspif);
		rd = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// no wait states on this slave
		if (apb_rsp.pready !== 1'b1) begin
			$display("[ERROR] %s: pready expected 1 actual %b", test_name, apb_rsp.pready);
			errors++;
		end
		@(posedge dspif);
		apb_req <= '0;
	endtask

	task automatic check_word(input string what, input apb_data_t exp, input apb_data_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic reg_write(input apb_addr_t a, input apb_data_t wd);
		apb_data_t rd;
		logic err;
		apb_xfer(1'b1, a, wd, rd, err);
		if (err !== 1'b0) begin
			$display("%s: write to offset 0x%0h was refused", test_name, a);
			errors++;
		end
	endtask

	task automatic reg_read(input apb_addr_t a, output apb_data_t rd);
		logic err;
		apb_xfer(1'b0, a, '0, rd, err);
		if (err !== 1'b0) begin
			$display("%s: read of offset 0x%0h was refused", test_name, a);
			errors++;
		end
	endtask

	// poll the status bit until the run is marked done
	task automatic wait_run_done;
		apb_data_t rd;
		int polls;
		rd = '0;
		polls = 0;
		while (rd[0] !== 1'b1 && polls < 100) begin
			reg_read(REG_STATUS, rd);
			polls++;
		end
		if (rd[0] !== 1'b1) begin
			$display("%s: shot run never reported completion", test_name);
			errors++;
		end
	endtask

	// one gate window of random samples on both adcs
	task automatic run_window(input int len, input int gap);
		sample_t win_a [MAXW];
		sample_t win_b [MAXW];
		acc_t sum_a;
		acc_t sum_b;
		for (int k = 0; k < len; k++) begin
			@(posedge dspif);
			win_a[k] = sample_t'($random(seed));
			win_b[k] = sample_t'($random(seed));
			adc[0] <= win_a[k];
			adc[1] <= win_b[k];
			gate <= 1'b1;
		end
		// samples outside the window must not count
		@(posedge dspif);
		gate <= 1'b0;
		adc[0] <= sample_t'($random(seed));
		adc[1] <= sample_t'($random(seed));
		sum_a = window_sum(win_a, len);
		sum_b = window_sum(win_b, len);
		exp_lane1.push_back(sel1 == 0 ? sum_a : sum_b);
		exp_lane2.push_back(sel2 == 0 ? sum_a : sum_b);
		exp_addr.push_back(addr_model);
		// buffer address sticks at the last entry
		if (addr_model != '1) begin
			addr_model = addr_model + 1'b1;
		end
		repeat (gap) @(posedge dspif);
	endtask

	task automatic run_windows(input int n);
		for (int w = 0; w < n; w++) begin
			run_window(1 + $unsigned($random(seed)) % 6, $unsigned($random(seed)) % 3);
		end
	endtask

	task automatic wait_writes_done;
		int n;
		n = 0;
		while (exp_addr.size() != 0 && n < 50) begin
			@(posedge dspif);
			n++;
		end
		if (exp_addr.size() != 0) begin
			$display("%s: %0d buffer writes never appeared", test_name, exp_addr.size());
			errors++;
			exp_lane1.delete();
			exp_lane2.delete();
			exp_addr.delete();
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_err = errors;
		tests_run++;
	endtask

	task automatic end_test;
		if (errors == test_start_err) begin
			$display("[PASS] %s", test_name);
		end else begin
			$display("[FAIL] %s, %0d errors", test_name, errors - test_start_err);
			tests_failed++;
		end
	endtask

	// processor model raises done after 3 to 10 cycles and goes idle 2 cycles later
	initial begin : proc_model
		int delay;
		procdone = '0;
		nobusy = '0;
		forever begin
			@(posedge dspif);
			if (!reset && !procreset) begin
				nobusy <= '0;
				delay = 3 + $unsigned($random(seed)) % 8;
				repeat (delay - 1) @(posedge dspif);
				procdone <= '1;
				repeat (2) @(posedge dspif);
				nobusy <= '1;
				// done drops once the sequencer holds the group in reset
				while (!procreset) @(posedge dspif);
				procdone <= '0;
			end
		end
	end

	// compares every buffer write against the expected queues
	initial begin : write_check
		acc_t exp1;
		acc_t exp2;
		acc_t expv;
		logic [AW-1:0] ea;
		forever begin
			@(negedge dspif);
			if (!reset && (acc_we[0] | acc_we[1] | acc_we[2] | acc_we[3])) begin
				if (exp_addr.size() == 0) begin
					$display("%s: buffer write with no window pending", test_name);
					errors++;
				end else begin
					exp1 = exp_lane1.pop_front();
					exp2 = exp_lane2.pop_front();
					ea = exp_addr.pop_front();
					for (int i = 0; i < NDLO; i++) begin
						expv = (i < NDLO1) ? exp1 : exp2;
						if (acc_we[i] !== 1'b1) begin
							$display("%s: channel %0d missed a buffer write", test_name, i);
							errors++;
						end else begin
							if (acc_data[i] !== expv) begin
								$display("[ERROR] %s: ch%0d data expected %0d actual %0d",
									test_name, i, expv, acc_data[i]);
								errors++;
							end
							if (acc_addr[i] !== ea) begin
								$display("[ERROR] %s: ch%0d addr expected %0d actual %0d",
									test_name, i, ea, acc_addr[i]);
								errors++;
							end
							if (meas[i] !== expv[ACC_WIDTH-1]) begin
								$display("[ERROR] %s: ch%0d meas expected %0b actual %0b",
									test_name, i, expv[ACC_WIDTH-1], meas[i]);
								errors++;
							end
						end
					end
				end
			end
		end
	end

	// whole run is a few microseconds
	initial begin
		#20us;
		$display("watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : main
		apb_data_t rd;
		apb_data_t val;
		logic err;
		apb_req = '0;
		adc[0] = '0;
		adc[1] = '0;
		gate = 1'b0;
		reset = 1'b1;
		repeat (8) @(posedge dspif);
		reset <= 1'b0;

		start_test("registers");
		val = $random(seed);
		reg_write(REG_NSHOT, val);
		reg_read(REG_NSHOT, rd);
		check_word("nshot readback", val, rd);
		reg_write(REG_LANESEL, 32'h6);
		reg_read(REG_LANESEL, rd);
		check_word("lanesel readback", 32'h6, rd);
		// back to adc 0 on lane 1 and adc 1 on lane 2
		reg_write(REG_LANESEL, 32'h4);
		apb_xfer(1'b1, REG_STATUS, 32'h1, rd, err);
		check_word("pslverr on status write", 32'h1, {31'd0, err});
		apb_xfer(1'b0, 8'h20, '0, rd, err);
		check_word("pslverr on unmapped read", 32'h1, {31'd0, err});
		end_test();

		start_test("shot run");
		reg_write(REG_NSHOT, 32'd3);
		fall_cnt = 0;
		reg_write(REG_CTRL, 32'h1);
		wait_run_done();
		reg_read(REG_SHOTS, rd);
		check_word("shots done", 32'd3, rd);
		check_word("processor starts", 32'd3, fall_cnt);
		reg_write(REG_CTRL, 32'h1);
		reg_read(REG_STATUS, rd);
		check_word("status after restart", 32'h0, rd);
		wait_run_done();
		end_test();

		start_test("accumulation");
		run_windows(6);
		wait_writes_done();
		end_test();

		start_test("addresses");
		run_windows(6);
		wait_writes_done();
		end_test();

		start_test("buffer reset");
		reg_write(REG_CTRL, 32'h2);
		reg_write(REG_CTRL, 32'h0);
		addr_model = '0;
		run_windows(2);
		wait_writes_done();
		end_test();

		start_test("lane swap");
		// lane 1 takes adc 1 and lane 2 takes adc 0
		reg_write(REG_LANESEL, 32'h1);
		sel1 = 1;
		sel2 = 0;
		run_windows(4);
		wait_writes_done();
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
hw/dsp_pkg.sv
hw/dsp_regs.sv
hw/shot_sequencer.sv
hw/bb_select.sv
hw/acc_writer.sv
hw/dsp_top.sv
tests/tb_dsp_top.sv

//--- Bender.yml
package:
  name: dsp_readout

sources:
  # package first, then the blocks, then the top level
  - files:
      - hw/dsp_pkg.sv
      - hw/dsp_regs.sv
      - hw/shot_sequencer.sv
      - hw/bb_select.sv
      - hw/acc_writer.sv
      - hw/dsp_top.sv
  - target: test
    files:
      - tests/tb_dsp_top.sv
